// File: common/soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ------------------------------------------------------------
// Bus geometry
// ------------------------------------------------------------
`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// ------------------------------------------------------------
// Address map
// ------------------------------------------------------------
`define SOC_RAM_BASE    32'h0000_0000
`define SOC_RAM_WORDS   1024
`define SOC_UART_BASE   32'h4000_0000
`define SOC_IRQ_BASE    32'h4000_1000
`define SOC_PERIPH_SPAN 32'h0000_1000

// Clock cycles per serial bit
`define SOC_UART_DIV 16
`define SOC_NUM_KEYS 4

`endif

// File: common/soc_pkg.sv
`include "soc_cfg.svh"

package soc_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    DECERR = 2'd3
  } axil_resp_e;

  // Bit positions in the pending vector
  typedef enum logic [2:0] {
    IRQ_KEY0    = 3'd0,
    IRQ_KEY1    = 3'd1,
    IRQ_KEY2    = 3'd2,
    IRQ_KEY3    = 3'd3,
    IRQ_UART_RX = 3'd4
  } irq_src_e;

  // Master side of an AXI4-Lite port
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic [`SOC_DATA_W-1:0]   wdata;
    logic [`SOC_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     bready;
    logic [`SOC_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     rready;
  } axil_req_t;

  // Slave side
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    axil_resp_e             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`SOC_DATA_W-1:0] rdata;
    axil_resp_e             rresp;
  } axil_rsp_t;

endpackage

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       baud_tick,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       txd
);

  // Data bits followed by the stop bit
  logic [8:0] shreg;
  logic [3:0] bit_cnt;

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      busy    <= 1'b0;
      txd     <= 1'b1;
      bit_cnt <= '0;
    end else if (start && !busy) begin
      busy    <= 1'b1;
      txd     <= 1'b0;
      bit_cnt <= '0;
    end else if (busy && baud_tick) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
        txd  <= 1'b1;
      end else begin
        txd <= shreg[0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      shreg <= {1'b1, data};
    end else if (busy && baud_tick) begin
      shreg <= {1'b1, shreg[8:1]};
    end
  end

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_rx (
  input  logic       clk,
  input  logic       RSTn,
  input  logic       rxd,
  output logic [7:0] data,
  output logic       done
);

  localparam int CNT_W = $clog2(`SOC_UART_DIV);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  rx_state_e        state;
  logic             rx_meta;
  logic             rx_sync;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shreg;
  logic             bit_end;

  // Counter is half a bit behind the edges, so bit_end lands mid-bit
  assign bit_end = (cnt == CNT_W'(`SOC_UART_DIV - 1));

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      done    <= 1'b0;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      done    <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Recheck at the middle of the start bit
          if (cnt == CNT_W'(`SOC_UART_DIV / 2 - 1)) begin
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (bit_end) begin
            done  <= rx_sync;
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
    if (state == RX_STOP && bit_end && rx_sync) begin
      data <= shreg;
    end
  end

endmodule

// File: uart/uart_ctrl.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_ctrl (
  input  logic               clk,
  input  logic               RSTn,
  input  soc_pkg::axil_req_t req,
  output soc_pkg::axil_rsp_t rsp,
  input  logic               rxd,
  output logic               txd,
  output logic               rx_event
);

  import soc_pkg::*;

  localparam int DIV_W = $clog2(`SOC_UART_DIV);

  logic [DIV_W-1:0]       div_cnt;
  logic                   baud_tick;
  logic                   tx_start;
  logic                   tx_busy;
  logic [7:0]             rx_data;
  logic                   rx_done;
  logic                   rx_valid;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   wr_go;
  logic                   rd_go;
  logic                   bvalid;
  logic                   rvalid;

  assign wr_go    = req.awvalid & req.wvalid & ~bvalid;
  assign rd_go    = req.arvalid & ~rvalid;
  // Writes to TX data while busy are dropped
  assign tx_start = wr_go & (req.awaddr[3:2] == 2'd0) & ~tx_busy;
  assign rx_event = rx_done;

  always_comb begin
    rsp.awready = wr_go;
    rsp.wready  = wr_go;
    rsp.bvalid  = bvalid;
    rsp.bresp   = OKAY;
    rsp.arready = rd_go;
    rsp.rvalid  = rvalid;
    rsp.rdata   = rdata_q;
    rsp.rresp   = OKAY;
  end

  // ------------------------------------------------------------
  // Baud tick realigned to each frame start
  // ------------------------------------------------------------
  assign baud_tick = (div_cnt == DIV_W'(`SOC_UART_DIV - 1));

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      div_cnt  <= '0;
      rx_valid <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      div_cnt  <= (tx_start || baud_tick) ? '0 : div_cnt + 1'b1;
      rx_valid <= (rx_valid & ~(rd_go && req.araddr[3:2] == 2'd1)) | rx_done;
      bvalid   <= wr_go | (bvalid & ~req.bready);
      rvalid   <= rd_go | (rvalid & ~req.rready);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      case (req.araddr[3:2])
        2'd1:    rdata_q <= `SOC_DATA_W'(rx_data);
        2'd2:    rdata_q <= `SOC_DATA_W'({rx_valid, tx_busy});
        default: rdata_q <= '0;
      endcase
    end
  end

  uart_tx u_tx (
    .clk       (clk),
    .RSTn      (RSTn),
    .baud_tick (baud_tick),
    .start     (tx_start),
    .data      (req.wdata[7:0]),
    .busy      (tx_busy),
    .txd       (txd)
  );

  uart_rx u_rx (
    .clk  (clk),
    .RSTn (RSTn),
    .rxd  (rxd),
    .data (rx_data),
    .done (rx_done)
  );

endmodule

// File: source/axil_ram.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axil_ram (
  input  logic               clk,
  input  logic               RSTn,
  input  soc_pkg::axil_req_t req,
  output soc_pkg::axil_rsp_t rsp
);

  import soc_pkg::*;

  localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [IDX_W-1:0]       wr_idx;
  logic [IDX_W-1:0]       rd_idx;
  logic                   wr_go;
  logic                   rd_go;
  logic                   bvalid;
  logic                   rvalid;

  // Word index sits above the byte offset
  assign wr_idx = req.awaddr[2 +: IDX_W];
  assign rd_idx = req.araddr[2 +: IDX_W];
  assign wr_go  = req.awvalid & req.wvalid & ~bvalid;
  assign rd_go  = req.arvalid & ~rvalid;

  always_comb begin
    rsp.awready = wr_go;
    rsp.wready  = wr_go;
    rsp.bvalid  = bvalid;
    rsp.bresp   = OKAY;
    rsp.arready = rd_go;
    rsp.rvalid  = rvalid;
    rsp.rdata   = rdata_q;
    rsp.rresp   = OKAY;
  end

  always_ff @(posedge clk) begin
    if (wr_go) begin
      for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
        if (req.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    if (rd_go) begin
      rdata_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      bvalid <= wr_go | (bvalid & ~req.bready);
      rvalid <= rd_go | (rvalid & ~req.rready);
    end
  end

endmodule

// File: source/irq_ctrl.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module irq_ctrl (
  input  logic                     clk,
  input  logic                     RSTn,
  input  soc_pkg::axil_req_t       req,
  output soc_pkg::axil_rsp_t       rsp,
  input  logic [`SOC_NUM_KEYS-1:0] keys,
  input  logic                     rx_event,
  output logic                     irq
);

  import soc_pkg::*;

  logic [`SOC_NUM_KEYS-1:0] key_meta;
  logic [`SOC_NUM_KEYS-1:0] key_sync;
  logic [`SOC_NUM_KEYS-1:0] key_prev;
  logic [`SOC_NUM_KEYS:0]   pending;
  logic [`SOC_NUM_KEYS:0]   enable;
  logic [`SOC_NUM_KEYS:0]   set;
  logic [`SOC_NUM_KEYS:0]   clr;
  logic [`SOC_DATA_W-1:0]   rdata_q;
  logic                     wr_go;
  logic                     rd_go;
  logic                     bvalid;
  logic                     rvalid;

  assign wr_go = req.awvalid & req.wvalid & ~bvalid;
  assign rd_go = req.arvalid & ~rvalid;

  always_comb begin
    rsp.awready = wr_go;
    rsp.wready  = wr_go;
    rsp.bvalid  = bvalid;
    rsp.bresp   = OKAY;
    rsp.arready = rd_go;
    rsp.rvalid  = rvalid;
    rsp.rdata   = rdata_q;
    rsp.rresp   = OKAY;
  end

  // Keys are active low so a press is a falling edge
  always_comb begin
    set = '0;
    set[IRQ_KEY0 +: `SOC_NUM_KEYS] = key_prev & ~key_sync;
    set[IRQ_UART_RX] = rx_event;
    clr = (wr_go && req.awaddr[3:2] == 2'd0) ? req.wdata[`SOC_NUM_KEYS:0] : '0;
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      key_meta <= '1;
      key_sync <= '1;
      key_prev <= '1;
      pending  <= '0;
      enable   <= '0;
      irq      <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      key_meta <= keys;
      key_sync <= key_meta;
      key_prev <= key_sync;
      // A new event wins over a clear in the same cycle
      pending  <= (pending & ~clr) | set;
      if (wr_go && req.awaddr[3:2] == 2'd1) begin
        enable <= req.wdata[`SOC_NUM_KEYS:0];
      end
      irq    <= |(pending & enable);
      bvalid <= wr_go | (bvalid & ~req.bready);
      rvalid <= rd_go | (rvalid & ~req.rready);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      case (req.araddr[3:2])
        2'd0:    rdata_q <= `SOC_DATA_W'(pending);
        2'd1:    rdata_q <= `SOC_DATA_W'(enable);
        default: rdata_q <= '0;
      endcase
    end
  end

endmodule

// File: source/axil_decoder.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module axil_decoder (
  input  logic               clk,
  input  logic               RSTn,
  input  soc_pkg::axil_req_t host_req,
  output soc_pkg::axil_rsp_t host_rsp,
  output soc_pkg::axil_req_t ram_req,
  input  soc_pkg::axil_rsp_t ram_rsp,
  output soc_pkg::axil_req_t uart_req,
  input  soc_pkg::axil_rsp_t uart_rsp,
  output soc_pkg::axil_req_t irq_req,
  input  soc_pkg::axil_rsp_t irq_rsp
);

  import soc_pkg::*;

  // Index order matches the slave array below
  typedef enum logic [1:0] {TGT_RAM, TGT_UART, TGT_IRQ, TGT_ERR} tgt_e;

  function automatic tgt_e decode(input logic [`SOC_ADDR_W-1:0] addr);
    tgt_e tgt;
    tgt = TGT_ERR;
    if (addr - `SOC_RAM_BASE < `SOC_RAM_WORDS * 4) begin
      tgt = TGT_RAM;
    end else if (addr - `SOC_UART_BASE < `SOC_PERIPH_SPAN) begin
      tgt = TGT_UART;
    end else if (addr - `SOC_IRQ_BASE < `SOC_PERIPH_SPAN) begin
      tgt = TGT_IRQ;
    end
    return tgt;
  endfunction

  tgt_e      aw_tgt;
  tgt_e      ar_tgt;
  tgt_e      wr_owner;
  tgt_e      rd_owner;
  logic      wr_pend;
  logic      rd_pend;
  axil_req_t s_req [4];
  axil_rsp_t s_rsp [4];
  axil_rsp_t err_rsp;
  logic      err_bvalid;
  logic      err_rvalid;

  assign aw_tgt = decode(host_req.awaddr);
  assign ar_tgt = decode(host_req.araddr);

  // Valids only reach the addressed slave, readies only the owner
  always_comb begin
    for (int t = 0; t < 4; t++) begin
      s_req[t] = host_req;
      s_req[t].awvalid = host_req.awvalid & ~wr_pend & (aw_tgt == tgt_e'(t));
      s_req[t].wvalid  = host_req.wvalid & ~wr_pend & (aw_tgt == tgt_e'(t));
      s_req[t].bready  = host_req.bready & wr_pend & (wr_owner == tgt_e'(t));
      s_req[t].arvalid = host_req.arvalid & ~rd_pend & (ar_tgt == tgt_e'(t));
      s_req[t].rready  = host_req.rready & rd_pend & (rd_owner == tgt_e'(t));
    end
  end

  assign ram_req  = s_req[TGT_RAM];
  assign uart_req = s_req[TGT_UART];
  assign irq_req  = s_req[TGT_IRQ];
  assign s_rsp    = '{ram_rsp, uart_rsp, irq_rsp, err_rsp};

  always_comb begin
    host_rsp.awready = ~wr_pend & s_rsp[aw_tgt].awready;
    host_rsp.wready  = ~wr_pend & s_rsp[aw_tgt].wready;
    host_rsp.bvalid  = wr_pend & s_rsp[wr_owner].bvalid;
    host_rsp.bresp   = s_rsp[wr_owner].bresp;
    host_rsp.arready = ~rd_pend & s_rsp[ar_tgt].arready;
    host_rsp.rvalid  = rd_pend & s_rsp[rd_owner].rvalid;
    host_rsp.rdata   = s_rsp[rd_owner].rdata;
    host_rsp.rresp   = s_rsp[rd_owner].rresp;
  end

  // ------------------------------------------------------------
  // Per-channel owners
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      wr_pend  <= 1'b0;
      wr_owner <= TGT_RAM;
      rd_pend  <= 1'b0;
      rd_owner <= TGT_RAM;
    end else begin
      if (host_req.awvalid && host_rsp.awready) begin
        wr_pend  <= 1'b1;
        wr_owner <= aw_tgt;
      end else if (host_rsp.bvalid && host_req.bready) begin
        wr_pend <= 1'b0;
      end
      if (host_req.arvalid && host_rsp.arready) begin
        rd_pend  <= 1'b1;
        rd_owner <= ar_tgt;
      end else if (host_rsp.rvalid && host_req.rready) begin
        rd_pend <= 1'b0;
      end
    end
  end

  // Unmapped addresses
  always_comb begin
    err_rsp.awready = s_req[TGT_ERR].awvalid & s_req[TGT_ERR].wvalid & ~err_bvalid;
    err_rsp.wready  = err_rsp.awready;
    err_rsp.bvalid  = err_bvalid;
    err_rsp.bresp   = DECERR;
    err_rsp.arready = s_req[TGT_ERR].arvalid & ~err_rvalid;
    err_rsp.rvalid  = err_rvalid;
    err_rsp.rdata   = '0;
    err_rsp.rresp   = DECERR;
  end

  always_ff @(posedge clk or negedge RSTn) begin
    if (!RSTn) begin
      err_bvalid <= 1'b0;
      err_rvalid <= 1'b0;
    end else begin
      if (err_rsp.awready) begin
        err_bvalid <= 1'b1;
      end else if (s_req[TGT_ERR].bready) begin
        err_bvalid <= 1'b0;
      end
      if (err_rsp.arready) begin
        err_rvalid <= 1'b1;
      end else if (s_req[TGT_ERR].rready) begin
        err_rvalid <= 1'b0;
      end
    end
  end

endmodule

// File: source/periph_soc.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module periph_soc (
  input  logic                     clk,
  input  logic                     RSTn,
  input  soc_pkg::axil_req_t       host_req,
  output soc_pkg::axil_rsp_t       host_rsp,
  input  logic                     rxd,
  output logic                     txd,
  input  logic [`SOC_NUM_KEYS-1:0] keys,
  output logic                     irq
);

  import soc_pkg::*;

  axil_req_t ram_req;
  axil_rsp_t ram_rsp;
  axil_req_t uart_req;
  axil_rsp_t uart_rsp;
  axil_req_t irq_req;
  axil_rsp_t irq_rsp;
  logic      rx_event;

  // ------------------------------------------------------------
  // Host bus fan-out
  // ------------------------------------------------------------
  axil_decoder u_decoder (
    .clk      (clk),
    .RSTn     (RSTn),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp),
    .uart_req (uart_req),
    .uart_rsp (uart_rsp),
    .irq_req  (irq_req),
    .irq_rsp  (irq_rsp)
  );

  axil_ram u_ram (
    .clk  (clk),
    .RSTn (RSTn),
    .req  (ram_req),
    .rsp  (ram_rsp)
  );

  // Receive event also feeds the interrupt block
  uart_ctrl u_uart (
    .clk      (clk),
    .RSTn     (RSTn),
    .req      (uart_req),
    .rsp      (uart_rsp),
    .rxd      (rxd),
    .txd      (txd),
    .rx_event (rx_event)
  );

  irq_ctrl u_irq (
    .clk      (clk),
    .RSTn     (RSTn),
    .req      (irq_req),
    .rsp      (irq_rsp),
    .keys     (keys),
    .rx_event (rx_event),
    .irq      (irq)
  );

endmodule

// File: sim/tb_periph_soc.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_periph_soc;

  import soc_pkg::*;

  localparam int N_RAM = 200;
  localparam int N_BAD = 20;
  localparam int N_TX  = 4;
  localparam int N_RX  = 3;
  localparam int N_KEY = 4;

  // Bus operations and serial frames set the cycle budget
  localparam int BUS_OPS = 2 * N_RAM + 2 * N_BAD + 3 * N_TX + 6 * N_RX + 10 * N_KEY;
  localparam int FRAMES  = N_TX + N_RX;
  localparam int unsigned LIMIT = 2 * (BUS_OPS * 20 + FRAMES * 12 * `SOC_UART_DIV);

  logic                     clk;
  logic                     RSTn;
  axil_req_t                host_req;
  axil_rsp_t                host_rsp;
  logic                     rxd;
  logic                     txd;
  logic [`SOC_NUM_KEYS-1:0] keys;
  logic                     irq;

  int unsigned              cycle_count = 0;
  logic [31:0]              model [`SOC_RAM_WORDS];
  bit                       touched [`SOC_RAM_WORDS];
  int                       touched_q [$];
  logic [31:0]              rdata;
  logic [31:0]              wdata;
  logic [3:0]               strb;
  logic [7:0]               tx_byte;
  logic [7:0]               rx_byte;
  logic [7:0]               got;
  int                       idx;
  int                       k;

  periph_soc uut (
    .clk      (clk),
    .RSTn     (RSTn),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .rxd      (rxd),
    .txd      (txd),
    .keys     (keys),
    .irq      (irq)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ------------------------------------------------------------
  // Checks and helpers
  // ------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Ready high about two cycles out of three
  function automatic logic draw_ready();
    return ($urandom_range(0, 2) != 0);
  endfunction

  function automatic logic in_window(input logic [31:0] a, input logic [31:0] base,
                                     input logic [31:0] size);
    return (a >= base) && (a < base + size);
  endfunction

  function automatic logic [31:0] random_unmapped();
    logic [31:0] a;
    a = 32'h0000_0000;
    while (in_window(a, `SOC_RAM_BASE, `SOC_RAM_WORDS * 4) ||
           in_window(a, `SOC_UART_BASE, `SOC_PERIPH_SPAN) ||
           in_window(a, `SOC_IRQ_BASE, `SOC_PERIPH_SPAN)) begin
      // Half the picks land near the peripheral windows
      if ($urandom_range(0, 1) == 0) begin
        a = $urandom & 32'hFFFF_FFFC;
      end else begin
        a = 32'h4000_0000 | ($urandom & 32'h0000_3FFC);
      end
    end
    return a;
  endfunction

  // All bus tasks start and end 2 ns after a rising edge
  task automatic bus_write(input string name, input logic [31:0] a, input logic [31:0] d,
                           input logic [3:0] s, input axil_resp_e exp_resp);
    logic [1:0] resp;
    host_req.awaddr  = a;
    host_req.awvalid = 1'b1;
    host_req.wdata   = d;
    host_req.wstrb   = s;
    host_req.wvalid  = 1'b1;
    host_req.bready  = 1'b0;
    @(negedge clk);
    while (!(host_rsp.awready && host_rsp.wready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    // Request stays up while the response is pending
    host_req.bready = draw_ready();
    @(negedge clk);
    check_value({name, " response latency"}, 32'd1, 32'(host_rsp.bvalid));
    check_value({name, " no accept while pending"}, 32'd0, 32'(host_rsp.awready));
    resp = host_rsp.bresp;
    check_value({name, " response code"}, 32'(exp_resp), 32'(resp));
    while (!host_req.bready) begin
      @(posedge clk);
      #2;
      host_req.bready = draw_ready();
      @(negedge clk);
      check_value({name, " response hold"}, 32'd1, 32'(host_rsp.bvalid));
      check_value({name, " response code hold"}, 32'(resp), 32'(host_rsp.bresp));
      check_value({name, " no accept while pending"}, 32'd0, 32'(host_rsp.awready));
    end
    @(posedge clk);
    #2;
    host_req.awvalid = 1'b0;
    host_req.wvalid  = 1'b0;
    host_req.bready  = 1'b0;
  endtask

  task automatic bus_read(input string name, input logic [31:0] a,
                          input axil_resp_e exp_resp, output logic [31:0] d);
    logic [1:0] resp;
    host_req.araddr  = a;
    host_req.arvalid = 1'b1;
    host_req.rready  = 1'b0;
    @(negedge clk);
    while (!host_rsp.arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    host_req.rready = draw_ready();
    @(negedge clk);
    check_value({name, " response latency"}, 32'd1, 32'(host_rsp.rvalid));
    check_value({name, " no accept while pending"}, 32'd0, 32'(host_rsp.arready));
    d    = host_rsp.rdata;
    resp = host_rsp.rresp;
    check_value({name, " response code"}, 32'(exp_resp), 32'(resp));
    while (!host_req.rready) begin
      @(posedge clk);
      #2;
      host_req.rready = draw_ready();
      @(negedge clk);
      check_value({name, " response hold"}, 32'd1, 32'(host_rsp.rvalid));
      check_value({name, " data hold"}, d, host_rsp.rdata);
      check_value({name, " response code hold"}, 32'(resp), 32'(host_rsp.rresp));
      check_value({name, " no accept while pending"}, 32'd0, 32'(host_rsp.arready));
    end
    @(posedge clk);
    #2;
    host_req.arvalid = 1'b0;
    host_req.rready  = 1'b0;
  endtask

  // 8N1 frame on rxd with the LSB first
  task automatic send_frame(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd = frame[i];
      repeat (`SOC_UART_DIV) @(posedge clk);
      #2;
    end
  endtask

  // Samples txd in the middle of each bit
  task automatic capture_frame(output logic [7:0] b);
    @(negedge clk);
    while (txd) begin
      @(negedge clk);
    end
    repeat (`SOC_UART_DIV / 2) @(negedge clk);
    check_value("uart tx start bit", 32'd0, 32'(txd));
    for (int i = 0; i < 8; i++) begin
      repeat (`SOC_UART_DIV) @(negedge clk);
      b[i] = txd;
    end
    repeat (`SOC_UART_DIV) @(negedge clk);
    check_value("uart tx stop bit", 32'd1, 32'(txd));
  endtask

  task automatic wait_for_irq(input logic level);
    @(negedge clk);
    while (irq !== level) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(23));
    host_req = '0;
    rxd      = 1'b1;
    keys     = '1;
    RSTn     = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    RSTn = 1'b1;
    @(negedge clk);
    check_value("reset bvalid", 32'd0, 32'(host_rsp.bvalid));
    check_value("reset rvalid", 32'd0, 32'(host_rsp.rvalid));
    check_value("reset txd", 32'd1, 32'(txd));
    check_value("reset irq", 32'd0, 32'(irq));
    @(posedge clk);
    #2;
    bus_read("reset pending", `SOC_IRQ_BASE, OKAY, rdata);
    check_value("reset pending value", 32'd0, rdata);
    bus_read("reset enable", `SOC_IRQ_BASE + 32'd4, OKAY, rdata);
    check_value("reset enable value", 32'd0, rdata);

    // First touch of a word writes all four bytes
    for (int n = 0; n < N_RAM; n++) begin
      if (touched_q.size() == 0 || $urandom_range(0, 1) == 0) begin
        idx = $urandom_range(0, `SOC_RAM_WORDS - 1);
      end else begin
        idx = touched_q[$urandom_range(0, touched_q.size() - 1)];
      end
      wdata = $urandom;
      strb  = touched[idx] ? 4'($urandom) : 4'hF;
      bus_write("ram write", `SOC_RAM_BASE + 32'(idx * 4), wdata, strb, OKAY);
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end
      if (!touched[idx]) begin
        touched[idx] = 1'b1;
        touched_q.push_back(idx);
      end
    end
    foreach (touched_q[i]) begin
      bus_read("ram read", `SOC_RAM_BASE + 32'(touched_q[i] * 4), OKAY, rdata);
      check_value("ram read data", model[touched_q[i]], rdata);
    end

    // Unmapped addresses
    for (int n = 0; n < N_BAD; n++) begin
      bus_write("unmapped write", random_unmapped(), $urandom, 4'hF, DECERR);
      bus_read("unmapped read", random_unmapped(), DECERR, rdata);
      check_value("unmapped read data", 32'd0, rdata);
    end

    // UART transmit with a second write while busy
    for (int n = 0; n < N_TX; n++) begin
      tx_byte = 8'($urandom);
      fork
        capture_frame(got);
        begin
          bus_write("uart tx write", `SOC_UART_BASE, 32'(tx_byte), 4'hF, OKAY);
          bus_read("uart tx status", `SOC_UART_BASE + 32'd8, OKAY, rdata);
          check_value("uart tx busy", 32'd1, 32'(rdata[0]));
          bus_write("uart tx busy write", `SOC_UART_BASE, 32'(~tx_byte), 4'hF, OKAY);
        end
      join
      check_value("uart tx frame", 32'(tx_byte), 32'(got));
      repeat (`SOC_UART_DIV) @(negedge clk);
      check_value("uart tx idle after frame", 32'd1, 32'(txd));
      @(posedge clk);
      #2;
    end

    // UART receive
    for (int n = 0; n < N_RX; n++) begin
      rx_byte = 8'($urandom);
      send_frame(rx_byte);
      rdata = '0;
      while (!rdata[1]) begin
        bus_read("uart rx status poll", `SOC_UART_BASE + 32'd8, OKAY, rdata);
      end
      bus_read("uart rx data", `SOC_UART_BASE + 32'd4, OKAY, rdata);
      check_value("uart rx data value", 32'(rx_byte), rdata);
      bus_read("uart rx status", `SOC_UART_BASE + 32'd8, OKAY, rdata);
      check_value("uart rx valid cleared", 32'd0, rdata);
      bus_read("uart rx pending", `SOC_IRQ_BASE, OKAY, rdata);
      check_value("uart rx pending value", 32'd1 << IRQ_UART_RX, rdata);
      bus_write("uart rx pending clear", `SOC_IRQ_BASE, 32'd1 << IRQ_UART_RX, 4'hF, OKAY);
    end

    // Key interrupts
    for (int n = 0; n < N_KEY; n++) begin
      k = $urandom_range(0, `SOC_NUM_KEYS - 1);
      keys[k] = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      keys[k] = 1'b1;
      rdata = '0;
      while (!rdata[k]) begin
        bus_read("key pending poll", `SOC_IRQ_BASE, OKAY, rdata);
      end
      check_value("key pending value", 32'd1 << k, rdata);
      repeat (3) begin
        @(negedge clk);
        check_value("irq masked", 32'd0, 32'(irq));
      end
      @(posedge clk);
      #2;
      bus_write("irq enable", `SOC_IRQ_BASE + 32'd4, 32'd1 << k, 4'hF, OKAY);
      bus_read("irq enable readback", `SOC_IRQ_BASE + 32'd4, OKAY, rdata);
      check_value("irq enable value", 32'd1 << k, rdata);
      wait_for_irq(1'b1);
      bus_write("key pending clear", `SOC_IRQ_BASE, 32'd1 << k, 4'hF, OKAY);
      wait_for_irq(1'b0);
      bus_read("key pending cleared", `SOC_IRQ_BASE, OKAY, rdata);
      check_value("key pending after clear", 32'd0, rdata);
      bus_write("irq disable", `SOC_IRQ_BASE + 32'd4, 32'd0, 4'hF, OKAY);
    end

    $display("Test passed");
    $finish;
  end

endmodule

// File: periph_soc.f
+incdir+common
common/soc_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_ctrl.sv
source/axil_ram.sv
source/irq_ctrl.sv
source/axil_decoder.sv
source/periph_soc.sv
sim/tb_periph_soc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_periph_soc
FILELIST  ?= periph_soc.f
OBJ_DIR   ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
